//--- build.f
+incdir+.
rvIsaPkg.sv
rvBusPkg.sv
pcUnit.sv
rvDecoder.sv
regFile.sv
rvAlu.sv
instrMem.sv
dataMem.sv
rvCore.sv
rvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rvCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

//--- rvCoreTb.sv
`include "rvCore_cfg.svh"

module rvCoreTb import rvBusPkg::*; ();

	localparam int PROG_WORDS = 56; // 48 mixed, 7 epilogue stores, 1 halt
	localparam logic [31:0] HALT_ADDR = 32'd220;
	localparam int MAX_CYCLES = 500;

	logic clk;
	logic rst;
	imemLoadT imemLoad;
	logic [`XLEN-1:0] pc;
	storeT store;

	integer seed;
	int cycles;
	logic [31:0] prog [64];
	logic [31:0] mRegs [32]; // reference model state
	logic [31:0] mMem [32];
	logic [31:0] mPc;
	logic expValid;
	logic [31:0] expAddr;
	logic [31:0] expData;

	rvCore UUT (
		.clk(clk),
		.rst(rst),
		.imemLoad(imemLoad),
		.pc(pc),
		.store(store)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int randBelow(int n);
		return int'(($random(seed) & 32'h7fff_ffff) % n);
	endfunction

	function automatic int randImm();
		return randBelow(4096) - 2048; // full signed 12-bit range
	endfunction

	function automatic logic [31:0] encR(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(int opc, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] encS(int rs1, int rs2, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	task automatic buildProgram();
		int written [$];
		int kind;
		int rd;
		int rs1;
		int rs2;
		int k;
		int w;
		int lastBranch;
		prog[0] = encI(19, 0, 1, 0, 1 + randBelow(2047)); // x1 positive
		prog[1] = encI(19, 0, 2, 0, -(1 + randBelow(2048))); // x2 negative
		for (int i = 3; i < 8; i++) begin
			prog[i - 1] = encI(19, 0, i, 0, randImm());
		end
		prog[7] = encI(19, 0, 0, 1, 77); // write to x0 is dropped
		prog[8] = encS(0, 0, 0); // so this stores zero
		written.push_back(0);
		prog[9] = encB(5, 2, 1, 8); // bge neg, pos falls through
		prog[10] = encB(5, 1, 2, 8); // bge pos, neg is taken
		prog[11] = encI(19, 0, 3, 3, 1); // skipped
		prog[12] = encS(0, 1, 4); // x1 to word 1
		prog[13] = encI(3, 2, 3, 0, 4); // read it back into x3
		prog[14] = encS(0, 3, 8); // loaded word shows on the trace
		written.push_back(1);
		written.push_back(2);
		lastBranch = 10;
		for (int idx = 15; idx < 48; idx++) begin
			kind = randBelow(8);
			rd = randBelow(8); // rd 0 now and then
			rs1 = randBelow(8);
			rs2 = randBelow(8);
			k = 1 + randBelow(4); // forward branch distance in words
			if (idx + k > 48) begin
				k = 48 - idx;
			end
			case (kind)
				0: prog[idx] = encR(0, 0, rd, rs1, rs2);
				1: prog[idx] = encR(32, 0, rd, rs1, rs2);
				2: prog[idx] = encR(0, 4, rd, rs1, rs2);
				3: prog[idx] = encI(19, 0, rd, rs1, randImm());
				4: prog[idx] = encI(3, 2, rd, 0, 4 * written[randBelow(written.size())]);
				5: begin
					w = randBelow(24);
					prog[idx] = encS(0, rs2, 4 * w);
					if (idx - lastBranch > 3) begin
						written.push_back(w); // no branch can jump over it
					end
				end
				6: begin
					prog[idx] = encB(0, rs1, rs2, 4 * k);
					lastBranch = idx;
				end
				default: begin
					prog[idx] = encB(5, rs1, rs2, 4 * k);
					lastBranch = idx;
				end
			endcase
		end
		for (int r = 1; r < 8; r++) begin
			prog[47 + r] = encS(0, r, 4 * (23 + r)); // x1..x7 to words 24..30
		end
		prog[55] = encB(0, 0, 0, 0); // halt
	endtask

	// interprets one instruction and predicts its store
	task automatic modelStep();
		logic [31:0] w;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] addr;
		logic [31:0] res;
		logic [31:0] nextPc;
		logic wr;
		w = prog[mPc[7:2]];
		v1 = mRegs[w[19:15]];
		v2 = mRegs[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		res = 32'd0;
		wr = 1'b0;
		nextPc = mPc + 32'd4;
		expValid = 1'b0;
		expAddr = 32'd0;
		expData = 32'd0;
		case (w[6:0])
			7'h33: begin
				wr = 1'b1;
				if (w[14:12] == 3'b100) begin
					res = v1 ^ v2;
				end else if (w[30]) begin
					res = v1 - v2;
				end else begin
					res = v1 + v2;
				end
			end
			7'h13: begin
				wr = 1'b1;
				res = v1 + immI;
			end
			7'h03: begin
				wr = 1'b1;
				addr = v1 + immI;
				res = mMem[addr[6:2]];
			end
			7'h23: begin
				addr = v1 + immS;
				expValid = 1'b1;
				expAddr = addr;
				expData = v2;
				mMem[addr[6:2]] = v2;
			end
			7'h63: begin
				if (w[14:12] == 3'b000 ? (v1 == v2) : ($signed(v1) >= $signed(v2))) begin
					nextPc = mPc + immB;
				end
			end
			default: ;
		endcase
		if (wr && w[11:7] != 5'd0) begin
			mRegs[w[11:7]] = res;
		end
		mPc = nextPc;
	endtask

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic compareCycle();
		checkValue("pc", pc, mPc);
		modelStep();
		checkValue("store.valid", {31'b0, store.valid}, {31'b0, expValid});
		if (expValid) begin
			checkValue("store.addr", store.addr, expAddr);
			checkValue("store.data", store.data, expData);
		end
	endtask

	initial begin
		rst = 1'b1;
		imemLoad = '0;
		seed = 93;
		mPc = 32'd0;
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = 32'd0;
			mMem[i] = 32'd0;
		end
		buildProgram();
		// rst stays high while the program loads, then three more cycles
		for (int i = 0; i < PROG_WORDS; i++) begin
			@(posedge clk);
			#1;
			imemLoad.valid = 1'b1;
			imemLoad.addr = 6'(i);
			imemLoad.instr = prog[i];
		end
		@(posedge clk);
		#1;
		imemLoad = '0;
		repeat (3) begin
			@(negedge clk);
			checkValue("pc", pc, 32'd0);
			checkValue("store.valid", {31'b0, store.valid}, 32'd0); // quiet in reset
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		cycles = 0;
		while (mPc != HALT_ADDR) begin
			if (cycles >= MAX_CYCLES) begin
				$display("program never reached the halt address within 500 cycles");
				$display("TEST FAIL");
				$fatal(1, "timeout");
			end
			@(negedge clk);
			compareCycle();
			cycles++;
		end
		repeat (4) begin
			@(negedge clk);
			compareCycle(); // pc must sit on the self-branch
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- rvCore.sv
`include "rvCore_cfg.svh"

module rvCore import rvIsaPkg::*, rvBusPkg::*; (
	input logic clk,
	input logic rst,
	input imemLoadT imemLoad,
	output logic [`XLEN-1:0] pc,
	output storeT store
);

	logic [31:0] instr;
	ctrlT ctrl;
	logic [`XLEN-1:0] rdata1;
	logic [`XLEN-1:0] rdata2;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluResult;
	logic aluTakeBranch;
	logic branchTaken;
	logic [`XLEN-1:0] memRdata;
	logic [`XLEN-1:0] wbData;

	pcUnit uPc (
		.clk(clk),
		.rst(rst),
		.takeBranch(branchTaken),
		.branchOffset(ctrl.imm),
		.pc(pc)
	);

	instrMem uImem (
		.clk(clk),
		.load(imemLoad),
		.addr(pc),
		.instr(instr)
	);

	rvDecoder uDec (
		.instr(instr),
		.ctrl(ctrl)
	);

	regFile uRegs (
		.clk(clk),
		.rst(rst),
		.rs1(instr[19:15]),
		.rs2(instr[24:20]),
		.rd(instr[11:7]),
		.we(ctrl.regWrite),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	assign aluB = ctrl.aluSrcImm ? ctrl.imm : rdata2; // imm or rs2

	rvAlu uAlu (
		.a(rdata1),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.takeBranch(aluTakeBranch)
	);

	assign branchTaken = ctrl.branch & aluTakeBranch;

	// one struct feeds the data memory and the store trace
	assign store = '{valid: ctrl.memWrite, addr: aluResult, data: rdata2};

	dataMem uDmem (
		.clk(clk),
		.rst(rst),
		.wr(store),
		.raddr(aluResult),
		.rdata(memRdata)
	);

	assign wbData = ctrl.memToReg ? memRdata : aluResult; // lw or ALU result

endmodule

//--- dataMem.sv
`include "rvCore_cfg.svh"

module dataMem import rvBusPkg::*; (
	input logic clk,
	input logic rst,
	input storeT wr,
	input logic [`XLEN-1:0] raddr,
	output logic [`XLEN-1:0] rdata
);

	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];
	logic [DMEM_AW-1:0] wrIdx;
	logic [DMEM_AW-1:0] rdIdx;

	// drop the byte offset, higher bits wrap
	assign wrIdx = wr.addr[2 +: DMEM_AW];
	assign rdIdx = raddr[2 +: DMEM_AW];

	always_ff @(posedge clk) begin
		if (wr.valid && !rst) begin
			mem[wrIdx] <= wr.data;
		end
	end

	assign rdata = mem[rdIdx]; // lw data, same cycle

endmodule

//--- instrMem.sv
`include "rvCore_cfg.svh"

module instrMem import rvBusPkg::*; (
	input logic clk,
	input imemLoadT load,
	input logic [`XLEN-1:0] addr, // byte address from pc
	output logic [31:0] instr
);

	logic [31:0] mem [`IMEM_WORDS];
	logic [IMEM_AW-1:0] rdIdx;

	always_ff @(posedge clk) begin
		if (load.valid) begin
			mem[load.addr] <= load.instr;
		end
	end

	// word index, upper bits wrap
	assign rdIdx = addr[2 +: IMEM_AW];
	assign instr = mem[rdIdx];

endmodule

//--- rvAlu.sv
`include "rvCore_cfg.svh"

module rvAlu import rvIsaPkg::*; (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input aluOpE op,
	output logic [`XLEN-1:0] result,
	output logic takeBranch
);

	always_comb begin
		result = '0; // compares leave the result at zero
		takeBranch = 1'b0;
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			XOR: result = a ^ b;
			CMPEQ: takeBranch = (a == b); // beq
			CMPGE: takeBranch = ($signed(a) >= $signed(b)); // bge
			default: begin
				result = '0;
				takeBranch = 1'b0;
			end
		endcase
	end

endmodule

//--- regFile.sv
`include "rvCore_cfg.svh"

module regFile (
	input logic clk,
	input logic rst,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic we,
	input logic [`XLEN-1:0] wdata,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2
);

	logic [`XLEN-1:0] regs [32];

	// x0 never written, writes blocked during reset
	always_ff @(posedge clk) begin
		if (we && !rst && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero whatever the array holds
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rvDecoder.sv
`include "rvCore_cfg.svh"

module rvDecoder import rvIsaPkg::*; (
	input logic [31:0] instr,
	output ctrlT ctrl
);

	opcodeE opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;

	assign opcode = opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	// B format keeps the implicit zero in bit 0
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};

	always_comb begin
		ctrl = '0; // unknown encodings act as a no-op
		ctrl.aluOp = ADD;
		case (opcode)
			OP: begin
				if (funct7 == F7_BASE && funct3 == F3_ADDSUB) begin
					ctrl.regWrite = 1'b1;
				end else if (funct7 == F7_SUB && funct3 == F3_ADDSUB) begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = SUB;
				end else if (funct7 == F7_BASE && funct3 == F3_XOR) begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = XOR;
				end
			end
			OPIMM: begin
				ctrl.regWrite = (funct3 == F3_ADDSUB); // addi only
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immI;
			end
			LOAD: begin
				ctrl.regWrite = (funct3 == F3_WORD);
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immI;
			end
			STORE: begin
				ctrl.memWrite = (funct3 == F3_WORD);
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immS;
			end
			BRANCH: begin
				ctrl.imm = immB;
				if (funct3 == F3_BEQ) begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = CMPEQ;
				end else if (funct3 == F3_BGE) begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = CMPGE;
				end
			end
			default: begin
				ctrl.aluOp = ADD;
			end
		endcase
	end

endmodule

//--- pcUnit.sv
`include "rvCore_cfg.svh"

module pcUnit (
	input logic clk,
	input logic rst,
	input logic takeBranch,
	input logic [`XLEN-1:0] branchOffset, // low zero bit already in place
	output logic [`XLEN-1:0] pc
);

	logic [`XLEN-1:0] pcReg;
	logic [`XLEN-1:0] nextPc;

	always_comb begin
		if (takeBranch) begin
			nextPc = pcReg + branchOffset; // taken branch
		end else begin
			nextPc = pcReg + `XLEN'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pcReg <= '0;
		end else begin
			pcReg <= nextPc;
		end
	end

	assign pc = pcReg;

endmodule

//--- rvBusPkg.sv
`include "rvCore_cfg.svh"

package rvBusPkg;

	localparam int IMEM_AW = $clog2(`IMEM_WORDS); // load port word address width

	// instruction memory load port, written while the core is in reset
	typedef struct packed {
		logic valid;
		logic [IMEM_AW-1:0] addr; // word address
		logic [31:0] instr;
	} imemLoadT;

	// data memory write, also the store trace at the top
	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] addr; // byte address
		logic [`XLEN-1:0] data;
	} storeT;

endpackage

//--- rvIsaPkg.sv
`include "rvCore_cfg.svh"

package rvIsaPkg;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OP = 7'b0110011, // add, sub, xor
		OPIMM = 7'b0010011, // addi
		LOAD = 7'b0000011, // lw
		STORE = 7'b0100011, // sw
		BRANCH = 7'b1100011 // beq, bge
	} opcodeE;

	// function codes
	localparam logic [2:0] F3_ADDSUB = 3'b000; // also addi
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_WORD = 3'b010; // lw and sw width
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		XOR = 3'd2,
		CMPEQ = 3'd3, // branch compare, result is zero
		CMPGE = 3'd4 // signed compare
	} aluOpE;

	// decoded control word, 40 bits
	typedef struct packed {
		logic aluSrcImm; // operand b from immediate
		logic memToReg; // write back the load data
		logic regWrite;
		logic memWrite;
		logic branch;
		aluOpE aluOp;
		logic [`XLEN-1:0] imm; // sign extended
	} ctrlT;

endpackage

//--- rvCore_cfg.svh
`ifndef RVCORE_CFG_SVH
`define RVCORE_CFG_SVH

`define XLEN 32 // data and address width

// depth in 32-bit words, power of two
`define IMEM_WORDS 64
`define DMEM_WORDS 32 // data memory depth

`endif
